// File: rtl/cart_settings.svh
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////
// SNES activity timing
////////////////////////////////////////////////////////////////////////

// CLK2 cycles with CPU clock low before the SNES counts as dead
`define CART_DEAD_TIMEOUT 18'd88000

// Depth of the strobe shift registers
`define CART_SYNC_DEPTH 8

////////////////////////////////////////////////////////////////////////
// PSRAM access timing
////////////////////////////////////////////////////////////////////////

`define CART_ROM_CYCLE_LEN 4'd7  // Start value of the access delay

`endif

// File: rtl/cart_pkg.sv
package cart_pkg;

  ////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////

  typedef logic [23:0] snes_addr_t;  // SNES A bus, bank included
  typedef logic [22:0] rom_addr_t;   // PSRAM word address
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;   // PSRAM data, two byte lanes

  ////////////////////////////////////////////////////////////////////////
  // MCU access FSM
  ////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    st_idle,
    st_mcu_rd_addr,  // Address on the bus, data captured every cycle
    st_mcu_rd_end,
    st_mcu_wr_addr,  // Write strobe held low
    st_mcu_wr_end
  } arb_state_t;

endpackage

// File: rtl/snes_sync_if.sv
`timescale 1ns/1ns

// Sampled SNES bus timing, sampler to arbiter
interface snes_sync_if;

  logic cycle_start;   // CPU clock rose
  logic cycle_end;     // CPU clock fell
  logic cpu_clk_high;  // Synchronized CPU clock level
  logic snes_dead;     // CPU clock stopped

  modport src (
    output cycle_start, cycle_end, cpu_clk_high, snes_dead
  );

  modport dst (
    input cycle_start, cycle_end, cpu_clk_high, snes_dead
  );

endinterface

// File: rtl/snes_bus_sync.sv
`timescale 1ns/1ns
`include "cart_settings.svh"

module snes_bus_sync (
  input  logic           CLK2,
  input  logic           rst_n,
  input  logic           snes_cpu_clk,
  snes_sync_if.src       sync
);

  logic [`CART_SYNC_DEPTH-1:0] cpu_clk_sr;  // Newest sample in bit 0
  logic [17:0]                 dead_cnt;
  logic                        snes_dead_q;

  ////////////////////////////////////////////////////////////////////////
  // Strobe sampling
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      cpu_clk_sr <= '1;
    end else begin
      cpu_clk_sr <= {cpu_clk_sr[`CART_SYNC_DEPTH-2:0], snes_cpu_clk};
    end
  end

  // Four stable old samples then a new level in stage 3
  assign sync.cycle_start  = (cpu_clk_sr[7:3] == 5'b00001);
  assign sync.cycle_end    = (cpu_clk_sr[7:3] == 5'b11110);
  assign sync.cpu_clk_high = cpu_clk_sr[3];

  ////////////////////////////////////////////////////////////////////////
  // Dead detection
  ////////////////////////////////////////////////////////////////////////

  // Counts low samples and holds once dead
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (cpu_clk_sr[3]) begin
      dead_cnt <= '0;
    end else if (!snes_dead_q) begin
      dead_cnt <= dead_cnt + 18'd1;
    end
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      snes_dead_q <= 1'b1;  // No SNES until the clock shows up
    end else if (cpu_clk_sr[3]) begin
      snes_dead_q <= 1'b0;
    end else if (dead_cnt > `CART_DEAD_TIMEOUT) begin
      snes_dead_q <= 1'b1;
    end
  end

  assign sync.snes_dead = snes_dead_q;

endmodule

// File: rtl/rom_arbiter.sv
`timescale 1ns/1ns
`include "cart_settings.svh"

module rom_arbiter (
  input  logic                 CLK2,
  input  logic                 rst_n,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  input  cart_pkg::snes_addr_t mcu_addr,
  input  logic                 rom_hit,
  input  cart_pkg::rom_word_t  rom_data_in,
  snes_sync_if.dst             sync,
  output logic                 mcu_rdy,
  output logic                 mcu_wr_hit,
  output logic                 mcu_hit,
  output cart_pkg::snes_addr_t access_addr,
  output cart_pkg::byte_t      mcu_din
);

  cart_pkg::arb_state_t state;
  logic [3:0]           delay_cnt;
  logic                 rd_pend;
  logic                 wr_pend;
  logic                 free_strobe;
  logic                 free_slot;
  logic                 access_end;
  logic                 mcu_rd_hit;

  assign access_end = (state == cart_pkg::st_mcu_rd_end) ||
                      (state == cart_pkg::st_mcu_wr_end);
  assign mcu_rd_hit = (state == cart_pkg::st_mcu_rd_addr);
  assign mcu_wr_hit = (state == cart_pkg::st_mcu_wr_addr);
  assign mcu_hit    = mcu_rd_hit | mcu_wr_hit;

  ////////////////////////////////////////////////////////////////////////
  // Request latch
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin  // Read wins over write
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) begin
      access_addr <= mcu_addr;
    end
  end

  // SNES cycle that does not touch ROM leaves the bus free
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= sync.cycle_start & ~rom_hit;
    end
  end

  assign free_slot = sync.cycle_end | free_strobe;

  ////////////////////////////////////////////////////////////////////////
  // Access FSM
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= cart_pkg::st_idle;
      delay_cnt <= '0;
    end else if (sync.snes_dead && sync.cpu_clk_high) begin
      state <= cart_pkg::st_idle;  // SNES woke up, retry later
    end else begin
      case (state)
        cart_pkg::st_idle: begin
          if (free_slot || sync.snes_dead) begin
            if (rd_pend) begin
              state     <= cart_pkg::st_mcu_rd_addr;
              delay_cnt <= `CART_ROM_CYCLE_LEN;
            end else if (wr_pend) begin
              state     <= cart_pkg::st_mcu_wr_addr;
              delay_cnt <= `CART_ROM_CYCLE_LEN;
            end
          end
        end
        cart_pkg::st_mcu_rd_addr: begin
          delay_cnt <= delay_cnt - 4'd1;
          if (delay_cnt == 4'd0) state <= cart_pkg::st_mcu_rd_end;
        end
        cart_pkg::st_mcu_wr_addr: begin
          delay_cnt <= delay_cnt - 4'd1;
          if (delay_cnt == 4'd0) state <= cart_pkg::st_mcu_wr_end;
        end
        default: state <= cart_pkg::st_idle;  // Both end states
      endcase
    end
  end

  // Last sample before the end state is the one that counts
  always_ff @(posedge CLK2) begin
    if (mcu_rd_hit) begin
      mcu_din <= access_addr[0] ? rom_data_in[7:0] : rom_data_in[15:8];
    end
  end

endmodule

// File: rtl/cart_main.sv
`timescale 1ns/1ns

module cart_main (
  input  logic                 CLK2,
  input  logic                 rst_n,

  // SNES side
  input  cart_pkg::snes_addr_t snes_addr,
  input  logic                 snes_read,
  input  logic                 snes_cs,       // Reserved for the enable logic
  input  logic                 snes_cpu_clk,
  input  cart_pkg::snes_addr_t rom_mask,
  output cart_pkg::byte_t      snes_data_out,
  output logic                 snes_data_oe,

  // MCU side
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  input  cart_pkg::snes_addr_t mcu_addr,
  input  cart_pkg::byte_t      mcu_dout,
  output logic                 mcu_rdy,
  output cart_pkg::byte_t      mcu_din,

  // PSRAM
  input  cart_pkg::rom_word_t  rom_data_in,
  output cart_pkg::rom_addr_t  rom_addr,
  output cart_pkg::rom_word_t  rom_data_out,
  output logic                 rom_data_oe,
  output logic                 rom_we,
  output logic                 rom_bhe,
  output logic                 rom_ble
);

  cart_pkg::snes_addr_t mapped_addr;
  cart_pkg::snes_addr_t access_addr;
  logic                 rom_hit;
  logic                 rom_addr0;
  logic                 mcu_hit;
  logic                 mcu_wr_hit;

  snes_sync_if sync_if ();

  snes_bus_sync u_sync (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_cpu_clk (snes_cpu_clk),
    .sync         (sync_if.src)
  );

  rom_arbiter u_arb (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .mcu_rrq     (mcu_rrq),
    .mcu_wrq     (mcu_wrq),
    .mcu_addr    (mcu_addr),
    .rom_hit     (rom_hit),
    .rom_data_in (rom_data_in),
    .sync        (sync_if.dst),
    .mcu_rdy     (mcu_rdy),
    .mcu_wr_hit  (mcu_wr_hit),
    .mcu_hit     (mcu_hit),
    .access_addr (access_addr),
    .mcu_din     (mcu_din)
  );

  ////////////////////////////////////////////////////////////////////////
  // Address map and ROM bus
  ////////////////////////////////////////////////////////////////////////

  assign rom_hit     = snes_addr[22] | snes_addr[15];
  assign mapped_addr = snes_addr & rom_mask;

  assign rom_addr  = mcu_hit ? access_addr[23:1] : mapped_addr[23:1];
  assign rom_addr0 = mcu_hit ? access_addr[0] : mapped_addr[0];

  // Byte enables are active low, odd address is the low lane
  assign rom_bhe = rom_addr0;
  assign rom_ble = ~rom_addr0;

  assign rom_we       = ~mcu_wr_hit;
  assign rom_data_oe  = mcu_wr_hit;
  assign rom_data_out = rom_addr0 ? {8'h00, mcu_dout} : {mcu_dout, 8'h00};

  // SNES read path
  assign snes_data_out = rom_addr0 ? rom_data_in[7:0] : rom_data_in[15:8];
  assign snes_data_oe  = ~snes_read & rom_hit;

endmodule

// File: verif/cart_checker.sv
`timescale 1ns/1ns
`include "cart_settings.svh"

module cart_checker (
  input  logic                 CLK2,
  input  logic                 rst_n,
  input  logic                 fast_expected,  // Set while the SNES is dead
  input  cart_pkg::snes_addr_t snes_addr,
  input  logic                 snes_read,
  input  cart_pkg::snes_addr_t rom_mask,
  input  cart_pkg::byte_t      snes_data_out,
  input  logic                 snes_data_oe,
  input  logic                 mcu_rrq,
  input  logic                 mcu_wrq,
  input  cart_pkg::snes_addr_t mcu_addr,
  input  cart_pkg::byte_t      mcu_dout,
  input  logic                 mcu_rdy,
  input  cart_pkg::byte_t      mcu_din,
  input  cart_pkg::rom_addr_t  rom_addr,
  input  cart_pkg::rom_word_t  rom_data_out,
  input  logic                 rom_data_oe,
  input  logic                 rom_we,
  input  logic                 rom_bhe,
  input  logic                 rom_ble
);

  cart_pkg::rom_word_t  shadow [0:4095];
  cart_pkg::snes_addr_t op_addr;
  cart_pkg::byte_t      op_data;
  logic                 op_write;
  logic                 op_busy;
  logic                 rdy_q;
  int                   op_cycles;
  int                   we_cycles;
  int                   errors;
  int                   test_errors;
  int                   tests_run;
  int                   tests_failed;

  // Same fill pattern as the PSRAM model's power-up content
  function automatic cart_pkg::rom_word_t pattern_word(input logic [11:0] idx);
    return {idx[7:0] ^ 8'hA5, idx[11:4] ^ 8'h3C};
  endfunction

  // Odd address is the low lane
  function automatic cart_pkg::byte_t lane(input cart_pkg::rom_word_t w, input logic a0);
    return a0 ? w[7:0] : w[15:8];
  endfunction

  task automatic fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic report_test(input string name);
    @(posedge CLK2);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("Test %-14s %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic check_idle();
    if (mcu_rdy !== 1'b1) fail("mcu_rdy not high after reset");
    if (rom_we !== 1'b1) fail("rom_we not high after reset");
    if (snes_data_oe !== 1'b0) fail("snes_data_oe not low after reset");
  endtask

  initial begin
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    op_busy      = 1'b0;
    for (int i = 0; i < 4096; i++) shadow[i] = pattern_word(i[11:0]);
  end

  //////////////////////////////////////////////////////////////////////
  // MCU access tracking
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK2) begin
    cart_pkg::snes_addr_t m;
    logic                 exp_oe;
    if (!rst_n) begin
      op_busy = 1'b0;
      rdy_q   = 1'b1;
    end else begin
      if (mcu_rrq || mcu_wrq) begin
        if (!mcu_rdy) fail("request issued while mcu_rdy low");
        op_busy   = 1'b1;
        op_write  = !mcu_rrq;  // Read wins
        op_addr   = mcu_addr;
        op_data   = mcu_dout;
        op_cycles = 0;
        we_cycles = 0;
      end else if (op_busy) begin
        op_cycles++;
      end

      if (!rom_we) begin
        we_cycles++;
        if (!op_busy || !op_write) begin
          fail("rom_we low without a pending MCU write");
        end else begin
          if (rom_addr !== op_addr[23:1])
            fail($sformatf("write rom_addr %h, expected %h", rom_addr, op_addr[23:1]));
          if (rom_bhe !== op_addr[0] || rom_ble !== ~op_addr[0])
            fail($sformatf("byte enables %b%b for address %h", rom_bhe, rom_ble, op_addr));
          if (rom_data_oe !== 1'b1) fail("rom_data_oe low during write");
          if (lane(rom_data_out, op_addr[0]) !== op_data)
            fail($sformatf("write lane %h, expected %h",
                           lane(rom_data_out, op_addr[0]), op_data));
        end
      end

      // Access done on the rise of mcu_rdy
      if (op_busy && !rdy_q && mcu_rdy) begin
        if (op_write) begin
          if (we_cycles == 0) fail("MCU write finished without a PSRAM write strobe");
          if (op_addr[0]) shadow[op_addr[12:1]][7:0] = op_data;
          else shadow[op_addr[12:1]][15:8] = op_data;
        end else if (mcu_din !== lane(shadow[op_addr[12:1]], op_addr[0])) begin
          fail($sformatf("read %h returned %h, expected %h", op_addr, mcu_din,
                         lane(shadow[op_addr[12:1]], op_addr[0])));
        end
        if (fast_expected && op_cycles > `CART_ROM_CYCLE_LEN + 4)
          fail($sformatf("access took %0d cycles while SNES dead", op_cycles));
        op_busy = 1'b0;
      end

      // SNES read data only while no MCU access owns the bus
      exp_oe = !snes_read && (snes_addr[22] || snes_addr[15]);
      if (snes_data_oe !== exp_oe) begin
        fail($sformatf("snes_data_oe %b for address %h read %b",
                       snes_data_oe, snes_addr, snes_read));
      end else if (exp_oe && mcu_rdy) begin
        m = snes_addr & rom_mask;
        if (snes_data_out !== lane(shadow[m[12:1]], m[0]))
          fail($sformatf("SNES read %h returned %h, expected %h", snes_addr,
                         snes_data_out, lane(shadow[m[12:1]], m[0])));
      end
      rdy_q = mcu_rdy;
    end
  end

endmodule

// File: verif/cart_assert.sv
`timescale 1ns/1ns
`include "cart_settings.svh"

module arbiter_assert (
  input logic                 CLK2,
  input logic                 rst_n,
  input cart_pkg::arb_state_t state,
  input logic                 mcu_rdy,
  input logic                 mcu_hit,
  input logic                 mcu_wr_hit,
  input logic                 rd_pend,
  input logic                 wr_pend
);

  logic [4:0] hit_cnt;  // Consecutive address state cycles so far

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      hit_cnt <= '0;
    end else if (mcu_hit) begin
      hit_cnt <= hit_cnt + 5'd1;
    end else begin
      hit_cnt <= '0;
    end
  end

  busy_not_ready: assert property (@(posedge CLK2) disable iff (!rst_n)
    state != cart_pkg::st_idle |-> !mcu_rdy)
    else $error("mcu_rdy high outside idle");

  write_not_read: assert property (@(posedge CLK2) disable iff (!rst_n)
    mcu_wr_hit |-> wr_pend && !rd_pend)
    else $error("write strobe while a read is pending or no write is pending");

  addr_state_len: assert property (@(posedge CLK2) disable iff (!rst_n)
    !(mcu_hit && hit_cnt >= 5'(`CART_ROM_CYCLE_LEN) + 5'd1))
    else $error("address state too long");

endmodule

bind rom_arbiter arbiter_assert u_assert (
  .CLK2       (CLK2),
  .rst_n      (rst_n),
  .state      (state),
  .mcu_rdy    (mcu_rdy),
  .mcu_hit    (mcu_hit),
  .mcu_wr_hit (mcu_wr_hit),
  .rd_pend    (rd_pend),
  .wr_pend    (wr_pend)
);

// File: verif/tb_cart_main.sv
`timescale 1ns/1ns
`include "cart_settings.svh"

module tb_cart_main;

  localparam int N_READS   = 24;
  localparam int N_WRITES  = 24;
  localparam int N_SNES    = 240;
  localparam int N_LIVE    = 24;
  localparam int ACC_LIMIT = 40;  // Slot wait plus one access
  localparam int TIMEOUT_CYCLES = (`CART_DEAD_TIMEOUT + 200 + N_SNES +
    (1 + N_READS + 2 * N_WRITES + N_LIVE) * ACC_LIMIT) * 5 / 4;

  logic                 CLK2;
  logic                 rst_n;
  cart_pkg::snes_addr_t snes_addr;
  logic                 snes_read;
  logic                 snes_cs;
  logic                 snes_cpu_clk;
  cart_pkg::snes_addr_t rom_mask;
  cart_pkg::byte_t      snes_data_out;
  logic                 snes_data_oe;
  logic                 mcu_rrq;
  logic                 mcu_wrq;
  cart_pkg::snes_addr_t mcu_addr;
  cart_pkg::byte_t      mcu_dout;
  logic                 mcu_rdy;
  cart_pkg::byte_t      mcu_din;
  cart_pkg::rom_word_t  rom_data_in;
  cart_pkg::rom_addr_t  rom_addr;
  cart_pkg::rom_word_t  rom_data_out;
  logic                 rom_data_oe;
  logic                 rom_we;
  logic                 rom_bhe;
  logic                 rom_ble;
  logic                 fast_expected;
  logic                 clk_run;
  logic [2:0]           phase;
  logic [31:0]          rng;
  int unsigned          cycles;
  cart_pkg::rom_word_t  psram [0:4095];
  cart_pkg::snes_addr_t wq[$];

  cart_main dut (.*);

  cart_checker chk (.*);

  always #2 CLK2 = ~CLK2;

  //////////////////////////////////////////////////////////////////////
  // PSRAM model and SNES CPU clock
  //////////////////////////////////////////////////////////////////////

  assign rom_data_in = psram[rom_addr[11:0]];

  always @(posedge CLK2) begin
    if (!rom_we && !rom_bhe) psram[rom_addr[11:0]][15:8] <= rom_data_out[15:8];
    if (!rom_we && !rom_ble) psram[rom_addr[11:0]][7:0] <= rom_data_out[7:0];
  end

  always @(posedge CLK2) begin
    if (clk_run) begin
      if (phase == 3'd5) begin  // 12 CLK2 cycles per CPU clock
        phase        <= 3'd0;
        snes_cpu_clk <= ~snes_cpu_clk;
      end else begin
        phase <= phase + 3'd1;
      end
    end
  end

  always @(posedge CLK2) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic cart_pkg::snes_addr_t rand_addr();
    logic [31:0] r;
    r = rand32();
    return {11'd0, r[12:0]};
  endfunction

  // One MCU access that returns once mcu_rdy is back
  task automatic mcu_access(input logic write, input cart_pkg::snes_addr_t addr);
    logic [31:0] r;
    r = rand32();
    @(posedge CLK2);
    mcu_rrq  <= ~write;
    mcu_wrq  <= write;
    mcu_addr <= addr;
    mcu_dout <= r[7:0];
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    @(negedge CLK2);
    while (!mcu_rdy) @(negedge CLK2);
  endtask

  task automatic snes_step();
    logic [31:0] r;
    r = rand32();
    @(posedge CLK2);
    snes_addr <= r[23:0];
    snes_read <= r[24] & r[25];  // Mostly reading
  endtask

  initial begin
    CLK2          = 1'b0;
    rst_n         = 1'b0;
    rng           = 32'd5575;
    cycles        = 0;
    snes_addr     = '0;
    snes_read     = 1'b1;
    snes_cs       = 1'b1;
    snes_cpu_clk  = 1'b0;
    rom_mask      = 24'h001FFF;
    mcu_rrq       = 1'b0;
    mcu_wrq       = 1'b0;
    mcu_addr      = '0;
    mcu_dout      = '0;
    fast_expected = 1'b0;
    clk_run       = 1'b0;
    phase         = 3'd0;
    for (int i = 0; i < 4096; i++) psram[i] = {i[7:0] ^ 8'hA5, i[11:4] ^ 8'h3C};
    repeat (3) @(posedge CLK2);
    rst_n <= 1'b1;
    @(negedge CLK2);
    chk.check_idle();
    chk.report_test("reset");

    // Clock held low since reset
    repeat (`CART_DEAD_TIMEOUT + 20) @(posedge CLK2);
    fast_expected <= 1'b1;
    mcu_access(1'b0, rand_addr());
    chk.report_test("dead_detect");

    for (int i = 0; i < N_READS; i++) mcu_access(1'b0, rand_addr());
    chk.report_test("mcu_read_dead");

    for (int i = 0; i < N_WRITES; i++) begin
      wq.push_back(rand_addr());
      mcu_access(1'b1, wq[i]);
    end
    foreach (wq[i]) mcu_access(1'b0, wq[i]);
    chk.report_test("mcu_write_dead");

    @(posedge CLK2);
    fast_expected <= 1'b0;
    clk_run       <= 1'b1;
    for (int i = 0; i < N_SNES; i++) snes_step();
    chk.report_test("snes_read");

    for (int i = 0; i < N_LIVE; i++) begin
      logic [31:0] pick;
      snes_step();
      pick = rand32();
      mcu_access(pick[3], rand_addr());
    end
    chk.report_test("mcu_live");

    @(negedge CLK2);
    $display("Done: %0d tests, %0d failed, %0d errors",
             chk.tests_run, chk.tests_failed, chk.errors);
    if (chk.errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+rtl
rtl/cart_pkg.sv
rtl/snes_sync_if.sv
rtl/snes_bus_sync.sv
rtl/rom_arbiter.sv
rtl/cart_main.sv
verif/cart_checker.sv
verif/cart_assert.sv
verif/tb_cart_main.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_cart_main -Mdir obj_dir

out=$(./obj_dir/Vtb_cart_main)
echo "$out"
echo "$out" | grep -q "Simulation passed"
